/* verilog/rv_pkg.sv */
package rv_pkg;

	localparam int XLEN = 32;

	// handshake states of the decode stage
	localparam logic ST_IDLE = 1'b0;
	localparam logic ST_HOLD = 1'b1;

	// rv32i major opcodes
	localparam logic [6:0] OP_LUI    = 7'b0110111;
	localparam logic [6:0] OP_AUIPC  = 7'b0010111;
	localparam logic [6:0] OP_JAL    = 7'b1101111;
	localparam logic [6:0] OP_JALR   = 7'b1100111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_IMM    = 7'b0010011;
	localparam logic [6:0] OP_REG    = 7'b0110011;
	localparam logic [6:0] OP_FENCE  = 7'b0001111;
	localparam logic [6:0] OP_SYSTEM = 7'b1110011;

	// alu operations seen by execute
	localparam logic [3:0] ALU_ADD   = 4'd0;
	localparam logic [3:0] ALU_SUB   = 4'd1;
	localparam logic [3:0] ALU_SLL   = 4'd2;
	localparam logic [3:0] ALU_SLT   = 4'd3;
	localparam logic [3:0] ALU_SLTU  = 4'd4;
	localparam logic [3:0] ALU_XOR   = 4'd5;
	localparam logic [3:0] ALU_SRL   = 4'd6;
	localparam logic [3:0] ALU_SRA   = 4'd7;
	localparam logic [3:0] ALU_OR    = 4'd8;
	localparam logic [3:0] ALU_AND   = 4'd9;
	localparam logic [3:0] ALU_PASSB = 4'd10;

	// jump kinds, branch conditions resolved in execute
	localparam logic [3:0] JMP_NONE = 4'd0;
	localparam logic [3:0] JMP_JAL  = 4'd1;
	localparam logic [3:0] JMP_JALR = 4'd2;
	localparam logic [3:0] JMP_BEQ  = 4'd3;
	localparam logic [3:0] JMP_BNE  = 4'd4;
	localparam logic [3:0] JMP_BLT  = 4'd5;
	localparam logic [3:0] JMP_BGE  = 4'd6;
	localparam logic [3:0] JMP_BLTU = 4'd7;
	localparam logic [3:0] JMP_BGEU = 4'd8;

	// writeback source
	localparam logic [1:0] WB_ALU = 2'd0;
	localparam logic [1:0] WB_MEM = 2'd1;
	localparam logic [1:0] WB_PC4 = 2'd2;
	localparam logic [1:0] WB_CSR = 2'd3;

	// immediate formats
	localparam logic [2:0] IMM_I = 3'd0;
	localparam logic [2:0] IMM_S = 3'd1;
	localparam logic [2:0] IMM_B = 3'd2;
	localparam logic [2:0] IMM_U = 3'd3;
	localparam logic [2:0] IMM_J = 3'd4;

	// machine csr addresses
	localparam logic [11:0] CSR_MSTATUS = 12'h300;
	localparam logic [11:0] CSR_MTVEC   = 12'h305;
	localparam logic [11:0] CSR_MEPC    = 12'h341;
	localparam logic [11:0] CSR_MCAUSE  = 12'h342;

	localparam logic [7:0] CAUSE_BREAKPOINT = 8'd3;
	localparam logic [7:0] CAUSE_ECALL_M    = 8'd11;

	// one instruction word, three field layouts
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r;
		struct packed {
			logic [11:0] imm12;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} i;
		struct packed {
			logic [6:0] imm_hi;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] imm_lo;
			logic [6:0] opcode;
		} s;
	} inst_u;

endpackage

/* verilog/decode_ctrl.sv */
`timescale 1ns/1ps

module decode_ctrl (
	input  rv_pkg::inst_u inst,
	output logic [3:0]    aluop,
	output logic          alu_src_a,
	output logic          alu_src_b,
	output logic [2:0]    imm_type,
	output logic          gpr_write,
	output logic [1:0]    wb_sel,
	output logic          csr_write,
	output logic          mem_read,
	output logic          mem_write,
	output logic [2:0]    mem_size,
	output logic          mem_unsigned,
	output logic [3:0]    jump,
	output logic          is_fence_i,
	output logic          trap_req,
	output logic [7:0]    trap_cause
);

	import rv_pkg::*;

	// shared by register and immediate arithmetic; sub only exists for registers
	function automatic logic [3:0] alu_from_funct3(
		input logic [2:0] f3,
		input logic       f7_bit5,
		input logic       is_reg
	);
		logic [3:0] op;
		case (f3)
			3'b000:  op = (is_reg && f7_bit5) ? ALU_SUB : ALU_ADD;
			3'b001:  op = ALU_SLL;
			3'b010:  op = ALU_SLT;
			3'b011:  op = ALU_SLTU;
			3'b100:  op = ALU_XOR;
			3'b101:  op = f7_bit5 ? ALU_SRA : ALU_SRL;
			3'b110:  op = ALU_OR;
			default: op = ALU_AND;
		endcase
		return op;
	endfunction

	always_comb begin
		aluop        = ALU_ADD;
		alu_src_a    = 1'b0;
		alu_src_b    = 1'b0;
		imm_type     = IMM_I;
		gpr_write    = 1'b0;
		wb_sel       = WB_ALU;
		csr_write    = 1'b0;
		mem_read     = 1'b0;
		mem_write    = 1'b0;
		mem_size     = 3'b000;
		mem_unsigned = 1'b0;
		jump         = JMP_NONE;
		is_fence_i   = 1'b0;
		trap_req     = 1'b0;
		trap_cause   = 8'd0;

		case (inst.r.opcode)
			OP_REG: begin
				aluop     = alu_from_funct3(inst.r.funct3, inst.r.funct7[5], 1'b1);
				gpr_write = 1'b1;
			end
			OP_IMM: begin
				// srai carries its flag in imm bit 10, same place as funct7 bit 5
				aluop     = alu_from_funct3(inst.r.funct3, inst.r.funct7[5], 1'b0);
				alu_src_b = 1'b1;
				gpr_write = 1'b1;
			end
			OP_LUI: begin
				aluop     = ALU_PASSB;
				alu_src_b = 1'b1;
				imm_type  = IMM_U;
				gpr_write = 1'b1;
			end
			OP_AUIPC: begin
				alu_src_a = 1'b1;
				alu_src_b = 1'b1;
				imm_type  = IMM_U;
				gpr_write = 1'b1;
			end
			OP_LOAD: begin
				alu_src_b    = 1'b1;
				gpr_write    = 1'b1;
				wb_sel       = WB_MEM;
				mem_read     = 1'b1;
				mem_size     = inst.i.funct3;
				mem_unsigned = inst.i.funct3[2];
			end
			OP_STORE: begin
				alu_src_b = 1'b1;
				imm_type  = IMM_S;
				mem_write = 1'b1;
				mem_size  = inst.s.funct3;
			end
			OP_JAL: begin
				// alu forms the target, rd gets pc+4
				alu_src_a = 1'b1;
				alu_src_b = 1'b1;
				imm_type  = IMM_J;
				gpr_write = 1'b1;
				wb_sel    = WB_PC4;
				jump      = JMP_JAL;
			end
			OP_JALR: begin
				alu_src_b = 1'b1;
				gpr_write = 1'b1;
				wb_sel    = WB_PC4;
				jump      = JMP_JALR;
			end
			OP_BRANCH: begin
				// target pc+imm in the alu, compare on rs1/rs2 in execute
				alu_src_a = 1'b1;
				alu_src_b = 1'b1;
				imm_type  = IMM_B;
				case (inst.r.funct3)
					3'b000:  jump = JMP_BEQ;
					3'b001:  jump = JMP_BNE;
					3'b100:  jump = JMP_BLT;
					3'b101:  jump = JMP_BGE;
					3'b110:  jump = JMP_BLTU;
					3'b111:  jump = JMP_BGEU;
					default: jump = JMP_NONE;
				endcase
			end
			OP_FENCE: begin
				is_fence_i = (inst.i.funct3 == 3'b001);
			end
			OP_SYSTEM: begin
				if (inst.i.funct3 == 3'b001) begin
					// csrrw: old csr value to rd, rs1 to the csr
					gpr_write = 1'b1;
					csr_write = 1'b1;
					wb_sel    = WB_CSR;
				end else if (inst.i.funct3 == 3'b000 && inst.i.rs1 == 5'd0
						&& inst.i.rd == 5'd0) begin
					if (inst.i.imm12 == 12'h000) begin
						trap_req   = 1'b1;
						trap_cause = CAUSE_ECALL_M;
					end else if (inst.i.imm12 == 12'h001) begin
						trap_req   = 1'b1;
						trap_cause = CAUSE_BREAKPOINT;
					end
				end
			end
			default: begin
				// unknown opcode leaves every write disabled
				aluop = ALU_ADD;
			end
		endcase
	end

endmodule

/* verilog/gpr_file.sv */
`timescale 1ns/1ps

module gpr_file (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    we,
	input  logic [4:0]              waddr,
	input  logic [rv_pkg::XLEN-1:0] wdata,
	input  logic [4:0]              raddr1,
	input  logic [4:0]              raddr2,
	output logic [rv_pkg::XLEN-1:0] rdata1,
	output logic [rv_pkg::XLEN-1:0] rdata2
);

	import rv_pkg::*;

	// x0 has no storage
	logic [XLEN-1:0] regs [1:31];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && waddr != 5'd0) begin
			regs[waddr] <= wdata;
		end
	end

	assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

/* verilog/csr_file.sv */
`timescale 1ns/1ps

module csr_file (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    we,
	input  logic [11:0]             waddr,
	input  logic [rv_pkg::XLEN-1:0] wdata,
	input  logic [11:0]             raddr,
	output logic [rv_pkg::XLEN-1:0] rdata,
	input  logic                    trap_we,
	input  logic [rv_pkg::XLEN-1:0] trap_pc,
	input  logic [7:0]              trap_cause,
	output logic [rv_pkg::XLEN-1:0] mtvec,
	output logic [rv_pkg::XLEN-1:0] mepc
);

	import rv_pkg::*;

	logic [XLEN-1:0] mstatus_q;
	logic [XLEN-1:0] mtvec_q;
	logic [XLEN-1:0] mepc_q;
	logic [XLEN-1:0] mcause_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			mstatus_q <= '0;
			mtvec_q   <= '0;
			mepc_q    <= '0;
			mcause_q  <= '0;
		end else begin
			if (we) begin
				case (waddr)
					CSR_MSTATUS: mstatus_q <= wdata;
					CSR_MTVEC:   mtvec_q   <= wdata;
					CSR_MEPC:    mepc_q    <= wdata;
					CSR_MCAUSE:  mcause_q  <= wdata;
					default:     mstatus_q <= mstatus_q;
				endcase
			end
			// trap capture comes last so it overrides a csr write in the same cycle
			if (trap_we) begin
				mepc_q   <= trap_pc;
				mcause_q <= {{(XLEN-8){1'b0}}, trap_cause};
			end
		end
	end

	always_comb begin
		case (raddr)
			CSR_MSTATUS: rdata = mstatus_q;
			CSR_MTVEC:   rdata = mtvec_q;
			CSR_MEPC:    rdata = mepc_q;
			CSR_MCAUSE:  rdata = mcause_q;
			default:     rdata = '0;
		endcase
	end

	// trap vector and return pc for fetch
	assign mtvec = mtvec_q;
	assign mepc  = mepc_q;

endmodule

/* verilog/imm_gen.sv */
`timescale 1ns/1ps

module imm_gen (
	input  rv_pkg::inst_u           inst,
	input  logic [2:0]              imm_type,
	output logic [rv_pkg::XLEN-1:0] sext_imm
);

	import rv_pkg::*;

	// b and j scatter their bits, easier on the flat word
	logic [31:0] w;

	assign w = inst;

	always_comb begin
		case (imm_type)
			IMM_I:   sext_imm = {{20{w[31]}}, inst.i.imm12};
			IMM_S:   sext_imm = {{20{w[31]}}, inst.s.imm_hi, inst.s.imm_lo};
			IMM_B:   sext_imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
			IMM_U:   sext_imm = {w[31:12], 12'b0};
			IMM_J:   sext_imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
			default: sext_imm = '0;
		endcase
	end

endmodule

/* verilog/idu.sv */
`timescale 1ns/1ps

module idu (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     if_valid,
	input  logic [rv_pkg::XLEN-1:0]  instruction,
	input  logic [rv_pkg::XLEN-1:0]  pc,
	output logic                     id_ready,
	output logic                     id_valid,
	input  logic                     exe_ready,
	input  logic                     gpr_we,
	input  logic [4:0]               wb_rd,
	input  logic [rv_pkg::XLEN-1:0]  wb_gpr_data,
	input  logic                     csr_we,
	input  logic [11:0]              wb_csr_addr,
	input  logic [rv_pkg::XLEN-1:0]  wb_csr_data,
	input  logic                     trap_we,
	input  logic [rv_pkg::XLEN-1:0]  wb_pc,
	input  logic [7:0]               wb_cause,
	output logic [rv_pkg::XLEN-1:0]  pc_e,
	output logic [rv_pkg::XLEN-1:0]  sext_imm,
	output logic [rv_pkg::XLEN-1:0]  rs1_data,
	output logic [rv_pkg::XLEN-1:0]  rs2_data,
	output logic [rv_pkg::XLEN-1:0]  rdata_csr,
	output logic [4:0]               rd_addr,
	output logic [3:0]               aluop,
	output logic                     alu_src_a,
	output logic                     alu_src_b,
	output logic                     gpr_write,
	output logic [1:0]               wb_sel,
	output logic                     csr_write,
	output logic                     mem_read,
	output logic                     mem_write,
	output logic [2:0]               mem_size,
	output logic                     mem_unsigned,
	output logic [3:0]               jump,
	output logic                     is_fence_i,
	output logic                     trap_req,
	output logic [7:0]               trap_cause,
	output logic [rv_pkg::XLEN-1:0]  mtvec,
	output logic [rv_pkg::XLEN-1:0]  mepc
);

	import rv_pkg::*;

	logic            state;
	logic            fetch_xfer;
	logic            exe_xfer;
	inst_u           inst_q;
	logic [XLEN-1:0] pc_q;
	logic [2:0]      imm_type;

	// one instruction in flight, so the state alone gives both handshake outputs
	assign id_valid = (state == ST_HOLD);
	assign id_ready = (state == ST_IDLE);

	assign fetch_xfer = if_valid && id_ready;
	assign exe_xfer   = id_valid && exe_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					if (fetch_xfer) begin
						state <= ST_HOLD;
					end
				end
				ST_HOLD: begin
					if (exe_xfer) begin
						state <= ST_IDLE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// held instruction and pc, stable while execute stalls
	always_ff @(posedge clk) begin
		if (fetch_xfer) begin
			inst_q <= instruction;
			pc_q   <= pc;
		end
	end

	assign pc_e    = pc_q;
	assign rd_addr = inst_q.r.rd;

	decode_ctrl i_decode_ctrl (
		.inst         (inst_q),
		.aluop        (aluop),
		.alu_src_a    (alu_src_a),
		.alu_src_b    (alu_src_b),
		.imm_type     (imm_type),
		.gpr_write    (gpr_write),
		.wb_sel       (wb_sel),
		.csr_write    (csr_write),
		.mem_read     (mem_read),
		.mem_write    (mem_write),
		.mem_size     (mem_size),
		.mem_unsigned (mem_unsigned),
		.jump         (jump),
		.is_fence_i   (is_fence_i),
		.trap_req     (trap_req),
		.trap_cause   (trap_cause)
	);

	gpr_file i_gpr_file (
		.clk    (clk),
		.reset  (reset),
		.we     (gpr_we),
		.waddr  (wb_rd),
		.wdata  (wb_gpr_data),
		.raddr1 (inst_q.r.rs1),
		.raddr2 (inst_q.r.rs2),
		.rdata1 (rs1_data),
		.rdata2 (rs2_data)
	);

	// csr address sits in the i-format immediate field
	csr_file i_csr_file (
		.clk        (clk),
		.reset      (reset),
		.we         (csr_we),
		.waddr      (wb_csr_addr),
		.wdata      (wb_csr_data),
		.raddr      (inst_q.i.imm12),
		.rdata      (rdata_csr),
		.trap_we    (trap_we),
		.trap_pc    (wb_pc),
		.trap_cause (wb_cause),
		.mtvec      (mtvec),
		.mepc       (mepc)
	);

	imm_gen i_imm_gen (
		.inst     (inst_q),
		.imm_type (imm_type),
		.sext_imm (sext_imm)
	);

endmodule

/* dv/idu_sva.sv */
`timescale 1ns/1ps

module idu_sva (
	input logic                    clk,
	input logic                    reset,
	input logic                    if_valid,
	input logic                    id_ready,
	input logic                    id_valid,
	input logic                    exe_ready,
	input logic [rv_pkg::XLEN-1:0] pc_e
);

	// only one side of the stage may be open at a time
	assert property (@(posedge clk) disable iff (reset) !(id_valid && id_ready))
		else $error("id_valid and id_ready high together");

	// execute stall keeps the held instruction
	assert property (@(posedge clk) disable iff (reset)
		id_valid && !exe_ready |=> id_valid && $stable(pc_e))
		else $error("held output changed during execute stall");

	assert property (@(posedge clk) disable iff (reset)
		$rose(id_valid) |-> $past(if_valid && id_ready))
		else $error("id_valid rose without a fetch transfer");

endmodule

bind idu idu_sva i_idu_sva (.*);

/* dv/tb_idu.sv */
`timescale 1ns/1ps

module tb_idu;

	import rv_pkg::*;

	localparam int CLK_PERIOD   = 100;
	localparam int NUM_TESTS    = 5;
	localparam int CYCLE_BUDGET = 200;
	localparam int MAX_WAIT     = 20;

	// masks over the packed control vector
	localparam logic [17:0] M_ALL    = 18'h3ffff;
	localparam logic [17:0] M_NO_ALU = 18'h00fff;
	localparam logic [17:0] M_NO_WB  = 18'h3f9ff;

	logic clk, reset, if_valid, id_ready, id_valid, exe_ready;
	logic [31:0] instruction, pc, pc_e, sext_imm, rs1_data, rs2_data, rdata_csr;
	logic gpr_we, csr_we, trap_we;
	logic [4:0] wb_rd, rd_addr;
	logic [31:0] wb_gpr_data, wb_csr_data, wb_pc, mtvec, mepc;
	logic [11:0] wb_csr_addr;
	logic [7:0] wb_cause, trap_cause;
	logic [3:0] aluop, jump;
	logic alu_src_a, alu_src_b, gpr_write, csr_write, mem_read, mem_write;
	logic mem_unsigned, is_fence_i, trap_req;
	logic [1:0] wb_sel;
	logic [2:0] mem_size;

	int seed;
	int errors;
	int checks;
	int accept_cycles;

	idu i_idu (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(NUM_TESTS * CYCLE_BUDGET * CLK_PERIOD);
		$display("timeout: the tests did not finish within %0d cycles", NUM_TESTS * CYCLE_BUDGET);
		$display("TEST FAILED");
		$finish;
	end

	// instruction encoders, straight from the rv32i formats
	function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
			input logic [6:0] op);
		return {f7, rs2, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [6:0] op);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], op};
	endfunction

	function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [6:0] op);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op};
	endfunction

	function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
			input logic [6:0] op);
		return {imm, rd, op};
	endfunction

	function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd,
			input logic [6:0] op);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op};
	endfunction

	task automatic check_value(input string test, input string what,
			input logic [31:0] expected, input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("FAILED %s: %s expected %h, actual %h", test, what, expected, actual);
		end
	endtask

	// every task starts and ends 10 ns after a rising edge
	task automatic send_instr(input logic [31:0] instr, input logic [31:0] addr);
		int waited;
		instruction = instr;
		pc          = addr;
		if_valid    = 1'b1;
		@(posedge clk);
		#10;
		waited = 1;
		while (!id_valid && waited < MAX_WAIT) begin
			@(posedge clk);
			#10;
			waited++;
		end
		if_valid      = 1'b0;
		accept_cycles = waited;
		if (!id_valid) begin
			errors++;
			$display("decode stage never accepted instruction %h", instr);
		end
	endtask

	task automatic release_instr(input string test);
		exe_ready = 1'b1;
		@(posedge clk);
		#10;
		exe_ready = 1'b0;
		check_value(test, "id_valid after release", 32'd0, 32'(id_valid));
		check_value(test, "id_ready after release", 32'd1, 32'(id_ready));
	endtask

	task automatic write_gpr(input logic [4:0] rd, input logic [31:0] data);
		gpr_we      = 1'b1;
		wb_rd       = rd;
		wb_gpr_data = data;
		@(posedge clk);
		#10;
		gpr_we = 1'b0;
	endtask

	task automatic write_csr(input logic [11:0] addr, input logic [31:0] data);
		csr_we      = 1'b1;
		wb_csr_addr = addr;
		wb_csr_data = data;
		@(posedge clk);
		#10;
		csr_we = 1'b0;
	endtask

	task automatic report_trap(input logic [31:0] epc, input logic [7:0] cause);
		trap_we  = 1'b1;
		wb_pc    = epc;
		wb_cause = cause;
		@(posedge clk);
		#10;
		trap_we = 1'b0;
	endtask

	task automatic reset_and_handshake();
		check_value("handshake", "id_valid after reset", 32'd0, 32'(id_valid));
		check_value("handshake", "id_ready after reset", 32'd1, 32'(id_ready));
		send_instr(i_type(12'h123, 5'd1, 3'b000, 5'd2, OP_IMM), 32'h0000_1000);
		check_value("handshake", "cycles to accept", 32'd1, 32'(accept_cycles));
		check_value("handshake", "id_ready while held", 32'd0, 32'(id_ready));
		check_value("handshake", "pc_e", 32'h0000_1000, pc_e);
		// execute stalls for a few cycles
		repeat (3) begin
			@(posedge clk);
			#10;
			check_value("handshake", "id_valid in stall", 32'd1, 32'(id_valid));
			check_value("handshake", "pc_e in stall", 32'h0000_1000, pc_e);
			check_value("handshake", "sext_imm in stall", 32'h0000_0123, sext_imm);
		end
		release_instr("handshake");
	endtask

	task automatic gpr_readback();
		logic [31:0] model [32];
		logic [4:0]  used [8];
		logic [4:0]  r;
		logic [31:0] data;
		for (int k = 0; k < 32; k++) begin
			model[k] = 32'd0;
		end
		for (int k = 0; k < 8; k++) begin
			r    = 5'($unsigned($random(seed)) % 31 + 1);
			data = $random(seed);
			write_gpr(r, data);
			model[r] = data;
			used[k]  = r;
		end
		write_gpr(5'd0, $random(seed));
		for (int k = 0; k < 8; k++) begin
			send_instr(r_type(7'b0, used[(k + 3) % 8], used[k], 3'b000, 5'(k + 1), OP_REG),
				32'(k * 4));
			check_value("gpr", "rs1_data", model[used[k]], rs1_data);
			check_value("gpr", "rs2_data", model[used[(k + 3) % 8]], rs2_data);
			check_value("gpr", "rd_addr", 32'(k + 1), 32'(rd_addr));
			release_instr("gpr");
		end
		send_instr(r_type(7'b0, 5'd0, 5'd0, 3'b000, 5'd1, OP_REG), 32'h40);
		check_value("gpr", "x0 read", 32'd0, rs1_data);
		release_instr("gpr");
	endtask

	task automatic imm_case(input string test, input logic [31:0] instr,
			input logic [31:0] expected);
		send_instr(instr, 32'h0000_0100);
		check_value(test, "sext_imm", expected, sext_imm);
		release_instr(test);
	endtask

	task automatic immediate_formats();
		logic [11:0] i12;
		logic [12:0] b13;
		logic [19:0] u20;
		logic [20:0] j21;
		for (int n = 0; n < 4; n++) begin
			i12 = 12'($random(seed));
			imm_case("imm_addi", i_type(i12, 5'd6, 3'b000, 5'd5, OP_IMM), {{20{i12[11]}}, i12});
			imm_case("imm_sw", s_type(i12, 5'd7, 5'd6, 3'b010, OP_STORE), {{20{i12[11]}}, i12});
			b13 = {12'($random(seed)), 1'b0};
			imm_case("imm_beq", b_type(b13, 5'd2, 5'd1, 3'b000, OP_BRANCH), {{19{b13[12]}}, b13});
			u20 = 20'($random(seed));
			imm_case("imm_lui", u_type(u20, 5'd3, OP_LUI), {u20, 12'h000});
			j21 = {20'($random(seed)), 1'b0};
			imm_case("imm_jal", j_type(j21, 5'd1, OP_JAL), {{11{j21[20]}}, j21});
		end
	endtask

	// vector: aluop, src a/b, gpr_write, wb_sel, csr/mem writes, jump, fence.i, trap
	task automatic ctrl_case(input string test, input logic [31:0] instr,
			input logic [17:0] expected, input logic [17:0] mask);
		logic [17:0] actual;
		send_instr(instr, 32'h0000_2000);
		actual = {aluop, alu_src_a, alu_src_b, gpr_write, wb_sel, csr_write, mem_read,
			mem_write, jump, is_fence_i, trap_req};
		check_value(test, "control", 32'(expected & mask), 32'(actual & mask));
	endtask

	task automatic control_decode();
		ctrl_case("ctrl_sub", r_type(7'b0100000, 5'd2, 5'd1, 3'b000, 5'd3, OP_REG),
			{ALU_SUB, 2'b00, 1'b1, WB_ALU, 3'b000, JMP_NONE, 2'b00}, M_ALL);
		release_instr("ctrl_sub");
		ctrl_case("ctrl_sra", r_type(7'b0100000, 5'd2, 5'd1, 3'b101, 5'd3, OP_REG),
			{ALU_SRA, 2'b00, 1'b1, WB_ALU, 3'b000, JMP_NONE, 2'b00}, M_ALL);
		release_instr("ctrl_sra");
		ctrl_case("ctrl_slti", i_type(12'hffb, 5'd1, 3'b010, 5'd3, OP_IMM),
			{ALU_SLT, 2'b01, 1'b1, WB_ALU, 3'b000, JMP_NONE, 2'b00}, M_ALL);
		release_instr("ctrl_slti");
		ctrl_case("ctrl_lw", i_type(12'd8, 5'd1, 3'b010, 5'd3, OP_LOAD),
			{ALU_ADD, 2'b01, 1'b1, WB_MEM, 3'b010, JMP_NONE, 2'b00}, M_ALL);
		check_value("ctrl_lw", "mem_size", 32'd2, 32'(mem_size));
		check_value("ctrl_lw", "mem_unsigned", 32'd0, 32'(mem_unsigned));
		release_instr("ctrl_lw");
		ctrl_case("ctrl_lbu", i_type(12'd8, 5'd1, 3'b100, 5'd3, OP_LOAD),
			{ALU_ADD, 2'b01, 1'b1, WB_MEM, 3'b010, JMP_NONE, 2'b00}, M_ALL);
		check_value("ctrl_lbu", "mem_size", 32'd4, 32'(mem_size));
		check_value("ctrl_lbu", "mem_unsigned", 32'd1, 32'(mem_unsigned));
		release_instr("ctrl_lbu");
		ctrl_case("ctrl_sh", s_type(12'd4, 5'd2, 5'd1, 3'b001, OP_STORE),
			{ALU_ADD, 2'b01, 1'b0, WB_ALU, 3'b001, JMP_NONE, 2'b00}, M_NO_WB);
		check_value("ctrl_sh", "mem_size", 32'd1, 32'(mem_size));
		release_instr("ctrl_sh");
		ctrl_case("ctrl_jal", j_type(21'd2048, 5'd1, OP_JAL),
			{ALU_ADD, 2'b11, 1'b1, WB_PC4, 3'b000, JMP_JAL, 2'b00}, M_ALL);
		release_instr("ctrl_jal");
		ctrl_case("ctrl_jalr", i_type(12'd4, 5'd5, 3'b000, 5'd1, OP_JALR),
			{ALU_ADD, 2'b01, 1'b1, WB_PC4, 3'b000, JMP_JALR, 2'b00}, M_ALL);
		release_instr("ctrl_jalr");
		ctrl_case("ctrl_bltu", b_type(13'd16, 5'd2, 5'd1, 3'b110, OP_BRANCH),
			{ALU_ADD, 2'b11, 1'b0, WB_ALU, 3'b000, JMP_BLTU, 2'b00}, M_NO_WB);
		release_instr("ctrl_bltu");
		ctrl_case("ctrl_lui", u_type(20'h12345, 5'd3, OP_LUI),
			{ALU_PASSB, 2'b01, 1'b1, WB_ALU, 3'b000, JMP_NONE, 2'b00}, M_ALL);
		release_instr("ctrl_lui");
		ctrl_case("ctrl_auipc", u_type(20'h00010, 5'd3, OP_AUIPC),
			{ALU_ADD, 2'b11, 1'b1, WB_ALU, 3'b000, JMP_NONE, 2'b00}, M_ALL);
		release_instr("ctrl_auipc");
		ctrl_case("ctrl_csrrw", i_type(CSR_MSTATUS, 5'd1, 3'b001, 5'd3, OP_SYSTEM),
			{ALU_ADD, 2'b00, 1'b1, WB_CSR, 3'b100, JMP_NONE, 2'b00}, M_NO_ALU);
		release_instr("ctrl_csrrw");
		ctrl_case("ctrl_fence_i", i_type(12'h000, 5'd0, 3'b001, 5'd0, OP_FENCE),
			{ALU_ADD, 2'b00, 1'b0, WB_ALU, 3'b000, JMP_NONE, 2'b10}, M_NO_ALU & M_NO_WB);
		release_instr("ctrl_fence_i");
	endtask

	task automatic trap_case(input string test, input logic [31:0] instr,
			input logic [7:0] cause);
		send_instr(instr, 32'h0000_3000);
		check_value(test, "trap_req", 32'd1, 32'(trap_req));
		check_value(test, "trap_cause", 32'(cause), 32'(trap_cause));
		check_value(test, "gpr_write", 32'd0, 32'(gpr_write));
		check_value(test, "csr_write", 32'd0, 32'(csr_write));
		release_instr(test);
	endtask

	task automatic csr_and_traps();
		logic [31:0] vec;
		logic [31:0] epc;
		logic [7:0]  cause;
		vec = $random(seed);
		write_csr(CSR_MTVEC, vec);
		check_value("csr", "mtvec output", vec, mtvec);
		send_instr(i_type(CSR_MTVEC, 5'd0, 3'b001, 5'd5, OP_SYSTEM), 32'h0000_0200);
		check_value("csr", "rdata_csr mtvec", vec, rdata_csr);
		release_instr("csr");
		trap_case("ecall", 32'h0000_0073, 8'd11);
		trap_case("ebreak", 32'h0010_0073, 8'd3);
		epc   = $random(seed);
		cause = 8'($random(seed));
		report_trap(epc, cause);
		check_value("trap", "mepc output", epc, mepc);
		send_instr(i_type(CSR_MCAUSE, 5'd0, 3'b001, 5'd5, OP_SYSTEM), 32'h0000_0204);
		check_value("trap", "rdata_csr mcause", {24'd0, cause}, rdata_csr);
		release_instr("trap");
		// trap and csr write to mepc in one cycle
		csr_we      = 1'b1;
		wb_csr_addr = CSR_MEPC;
		wb_csr_data = ~epc;
		report_trap(epc + 32'd4, cause);
		csr_we = 1'b0;
		check_value("trap", "mepc with csr write", epc + 32'd4, mepc);
	endtask

	initial begin
		seed        = 32'h4ebe;
		errors      = 0;
		checks      = 0;
		reset       = 1'b1;
		if_valid    = 1'b0;
		instruction = 32'd0;
		pc          = 32'd0;
		exe_ready   = 1'b0;
		gpr_we      = 1'b0;
		wb_rd       = 5'd0;
		wb_gpr_data = 32'd0;
		csr_we      = 1'b0;
		wb_csr_addr = 12'd0;
		wb_csr_data = 32'd0;
		trap_we     = 1'b0;
		wb_pc       = 32'd0;
		wb_cause    = 8'd0;
		repeat (3) @(posedge clk);
		#10;
		reset = 1'b0;
		reset_and_handshake();
		gpr_readback();
		immediate_formats();
		control_decode();
		csr_and_traps();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* idu.f */
verilog/rv_pkg.sv
verilog/decode_ctrl.sv
verilog/gpr_file.sv
verilog/csr_file.sv
verilog/imm_gen.sv
verilog/idu.sv
dv/idu_sva.sv
dv/tb_idu.sv

/* Makefile */
TOP = tb_idu

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f idu.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f idu.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
